// ==== mem_ex_latches.f ====
+incdir+common
common/mem_ex_pkg.sv
hw/queue_nm/queue_nm.sv
hw/operand_wakeup.sv
hw/ex_issue.sv
hw/mem_ex_latches.sv
tests/tb_mem_ex_latches.sv

// ==== Bender.yml ====
package:
  name: mem_ex_latches

export_include_dirs:
  - common

sources:
  - files:
      - common/mem_ex_pkg.sv
      - hw/queue_nm/queue_nm.sv
      - hw/operand_wakeup.sv
      - hw/ex_issue.sv
      - hw/mem_ex_latches.sv
  - target: test
    files:
      - tests/tb_mem_ex_latches.sv

// ==== tests/tb_mem_ex_latches.sv ====
`default_nettype none
`include "mem_ex_settings.svh"

module tb_mem_ex_latches;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int Q_LEN       = `MEM_EX_Q_LENGTH;
    localparam int N_OPS       = `MEM_EX_NUM_OPS;
    localparam int WAIT_LIMIT  = 64;

    logic                      clk = 1'b0;
    logic                      arst_n;
    logic                      flush;
    logic                      mem_valid;
    mem_ex_pkg::mem_ex_entry_t mem_entry;
    mem_ex_pkg::result_bcast_t bcast;
    logic                      ex_ready;
    logic                      mem_ready;
    logic                      ex_valid;
    mem_ex_pkg::mem_ex_entry_t ex_entry;

    // expected entries, oldest first, output register included
    mem_ex_pkg::mem_ex_entry_t sb [$];

    // set when ex_valid was high and not taken in the last cycle
    logic                      hold_pending;
    mem_ex_pkg::mem_ex_entry_t held_entry;

    int n_errors;
    int n_checks;

    always #4 clk = ~clk;

    mem_ex_latches DUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .flush     (flush),
        .mem_valid (mem_valid),
        .mem_entry (mem_entry),
        .bcast     (bcast),
        .ex_ready  (ex_ready),
        .mem_ready (mem_ready),
        .ex_valid  (ex_valid),
        .ex_entry  (ex_entry)
    );

    // random entry, all operands awake unless sleep_slot names one
    function automatic mem_ex_pkg::mem_ex_entry_t make_entry(
        input int                       sleep_slot,
        input logic [`MEM_EX_TAG_W-1:0] sleep_tag
    );
        mem_ex_pkg::mem_ex_entry_t e;
        for (int s = 0; s < N_OPS; s++) begin
            e.mod[s].wake  = 1'b1;
            e.mod[s].tag   = `MEM_EX_TAG_W'($urandom);
            e.mod[s].value = `MEM_EX_VAL_W'($urandom);
        end
        if (sleep_slot >= 0) begin
            e.mod[sleep_slot].wake = 1'b0;
            e.mod[sleep_slot].tag  = sleep_tag;
        end
        e.fix.eip      = `MEM_EX_EIP_W'($urandom);
        e.fix.aluk     = `MEM_EX_ALUK_W'($urandom);
        e.fix.dest_tag = `MEM_EX_TAG_W'($urandom);
        e.fix.opsize   = `MEM_EX_OPSIZE_W'($urandom);
        return e;
    endfunction

    function automatic mem_ex_pkg::result_bcast_t make_bcast(
        input logic [`MEM_EX_TAG_W-1:0] tag,
        input logic [`MEM_EX_VAL_W-1:0] value
    );
        mem_ex_pkg::result_bcast_t b;
        b.valid = 1'b1;
        b.tag   = tag;
        b.value = value;
        return b;
    endfunction

    // expected effect of a broadcast on every entry still waiting
    task automatic apply_bcast(input mem_ex_pkg::result_bcast_t b);
        mem_ex_pkg::mem_ex_entry_t e;
        if (b.valid) begin
            foreach (sb[i]) begin
                e = sb[i];
                for (int s = 0; s < N_OPS; s++) begin
                    if (!e.mod[s].wake && e.mod[s].tag == b.tag) begin
                        e.mod[s].wake  = 1'b1;
                        e.mod[s].value = b.value;
                    end
                end
                sb[i] = e;
            end
        end
    endtask

    task automatic check_bit(input string name, input logic act, input logic exp);
        n_checks++;
        if (act !== exp) begin
            $display("FAILED t=%0t %s exp=%b got=%b", $time, name, exp, act);
            n_errors++;
        end
    endtask

    // sample outputs at the falling edge, then drive and update the model
    task automatic drive_cycle(
        input  logic                      valid,
        input  mem_ex_pkg::mem_ex_entry_t entry,
        input  mem_ex_pkg::result_bcast_t b,
        input  logic                      rdy,
        input  logic                      fl,
        output logic                      accepted
    );
        mem_ex_pkg::mem_ex_entry_t exp;
        @(negedge clk);
        if (hold_pending) begin
            n_checks++;
            if (ex_valid !== 1'b1) begin
                $display("FAILED t=%0t ex_valid exp=1 got=%b", $time, ex_valid);
                n_errors++;
            end else if (ex_entry !== held_entry) begin
                $display("FAILED t=%0t ex_entry exp=%h got=%h", $time, held_entry, ex_entry);
                n_errors++;
            end
        end
        accepted  = valid && mem_ready && !fl;
        mem_valid = valid;
        mem_entry = entry;
        bcast     = b;
        ex_ready  = rdy;
        flush     = fl;
        hold_pending = ex_valid && !rdy && !fl;
        held_entry   = ex_entry;
        // transfer at the coming rising edge
        if (ex_valid && rdy) begin
            n_checks++;
            if (sb.size() == 0) begin
                $display("unexpected entry at ex_entry at %0t with eip %h", $time,
                         ex_entry.fix.eip);
                n_errors++;
            end else begin
                exp = sb.pop_front();
                if (ex_entry !== exp) begin
                    $display("FAILED t=%0t ex_entry exp=%h got=%h", $time, exp, ex_entry);
                    n_errors++;
                end
            end
        end
        if (fl) begin
            sb.delete();
        end else begin
            if (accepted) begin
                sb.push_back(entry);
            end
            apply_bcast(b);
        end
    endtask

    task automatic idle_cycle(input logic rdy);
        logic acc;
        drive_cycle(1'b0, '0, '0, rdy, 1'b0, acc);
    endtask

    task automatic push_entry(
        input mem_ex_pkg::mem_ex_entry_t entry,
        input mem_ex_pkg::result_bcast_t b,
        input logic                      rdy
    );
        logic acc;
        int   tries;
        acc   = 1'b0;
        tries = 0;
        while (!acc && tries < WAIT_LIMIT) begin
            drive_cycle(1'b1, entry, b, rdy, 1'b0, acc);
            tries++;
        end
        if (!acc) begin
            $display("entry with eip %h was never accepted", entry.fix.eip);
            n_errors++;
        end
    endtask

    // run with ex_ready high until every expected entry has left
    task automatic drain();
        int cycles;
        cycles = 0;
        while ((sb.size() != 0 || ex_valid) && cycles < WAIT_LIMIT) begin
            idle_cycle(1'b1);
            cycles++;
        end
        if (sb.size() != 0 || ex_valid) begin
            $display("timeout while draining at %0t, %0d entries still expected",
                     $time, sb.size());
            n_errors++;
        end
    endtask

    task automatic test_reset_state();
        idle_cycle(1'b0);
        check_bit("mem_ready", mem_ready, 1'b1);
        check_bit("ex_valid", ex_valid, 1'b0);
    endtask

    task automatic test_in_order();
        for (int i = 0; i < 12; i++) begin
            push_entry(make_entry(-1, '0), '0, ($urandom % 4) != 0);
        end
        drain();
    endtask

    task automatic test_blocked_head();
        logic acc;
        push_entry(make_entry(1, 4'h5), '0, 1'b1);
        push_entry(make_entry(-1, '0), '0, 1'b1);
        push_entry(make_entry(-1, '0), '0, 1'b1);
        repeat (4) begin
            idle_cycle(1'b1);
            check_bit("ex_valid", ex_valid, 1'b0);
        end
        // wrong producer, head stays asleep
        drive_cycle(1'b0, '0, make_bcast(4'h6, $urandom), 1'b1, 1'b0, acc);
        repeat (3) begin
            idle_cycle(1'b1);
            check_bit("ex_valid", ex_valid, 1'b0);
        end
        drive_cycle(1'b0, '0, make_bcast(4'h5, $urandom), 1'b1, 1'b0, acc);
        drain();
    endtask

    task automatic test_same_cycle_wake();
        push_entry(make_entry(0, 4'h9), make_bcast(4'h9, $urandom), 1'b1);
        push_entry(make_entry(-1, '0), '0, 1'b1);
        drain();
    endtask

    task automatic test_backpressure();
        logic acc;
        logic stalled;
        int   n_acc;
        stalled = 1'b0;
        n_acc   = 0;
        for (int i = 0; i < 2 * Q_LEN + 4 && !stalled; i++) begin
            drive_cycle(1'b1, make_entry(-1, '0), '0, 1'b0, 1'b0, acc);
            if (acc) begin
                n_acc++;
            end else begin
                stalled = 1'b1;
            end
        end
        n_checks++;
        if (!stalled) begin
            $display("mem_ready never fell with ex_ready held low");
            n_errors++;
        end else if (n_acc != Q_LEN + 1) begin
            $display("FAILED t=%0t accepted_count exp=%0d got=%0d", $time, Q_LEN + 1, n_acc);
            n_errors++;
        end
        // nothing pops while ex_ready stays low
        idle_cycle(1'b0);
        check_bit("mem_ready", mem_ready, 1'b0);
        drain();
        check_bit("mem_ready", mem_ready, 1'b1);
    endtask

    task automatic test_flush();
        logic acc;
        repeat (Q_LEN) begin
            push_entry(make_entry(-1, '0), '0, 1'b0);
        end
        // the entry offered with the flush is dropped too
        drive_cycle(1'b1, make_entry(-1, '0), '0, 1'b0, 1'b1, acc);
        idle_cycle(1'b0);
        check_bit("ex_valid", ex_valid, 1'b0);
        check_bit("mem_ready", mem_ready, 1'b1);
        repeat (3) begin
            idle_cycle(1'b1);
            check_bit("ex_valid", ex_valid, 1'b0);
        end
        repeat (3) begin
            push_entry(make_entry(-1, '0), '0, 1'b1);
        end
        drain();
    endtask

    initial begin
        void'($urandom(32'h09a7_4c46));
        n_errors     = 0;
        n_checks     = 0;
        arst_n       = 1'b0;
        flush        = 1'b0;
        mem_valid    = 1'b0;
        mem_entry    = '0;
        bcast        = '0;
        ex_ready     = 1'b0;
        hold_pending = 1'b0;
        held_entry   = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        test_reset_state();
        test_in_order();
        test_blocked_head();
        test_same_cycle_wake();
        test_backpressure();
        test_flush();

        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // last resort if a wait loop itself never returns
    initial begin
        #100_000;
        $display("watchdog expired before the tests finished");
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/mem_ex_latches.sv ====
`default_nettype none
`include "mem_ex_settings.svh"

module mem_ex_latches (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      flush,
    input  logic                      mem_valid,
    input  mem_ex_pkg::mem_ex_entry_t mem_entry,
    input  mem_ex_pkg::result_bcast_t bcast,
    input  logic                      ex_ready,
    output logic                      mem_ready,
    output logic                      ex_valid,
    output mem_ex_pkg::mem_ex_entry_t ex_entry
);

    mem_ex_pkg::mem_ex_mod_t      old_mod [`MEM_EX_Q_LENGTH];
    mem_ex_pkg::mem_ex_mod_t      new_mod [`MEM_EX_Q_LENGTH];
    logic [`MEM_EX_Q_LENGTH-1:0] modify_mask;
    mem_ex_pkg::mem_ex_entry_t    woken_entry;
    mem_ex_pkg::mem_ex_mod_t      head_m;
    mem_ex_pkg::mem_ex_fix_t      head_n;
    logic                         full;
    logic                         empty;
    logic                         rd;

    // broadcast compare over the queue and the entry at the door
    operand_wakeup u_wakeup (
        .old_mod     (old_mod),
        .in_entry    (mem_entry),
        .bcast       (bcast),
        .new_mod     (new_mod),
        .modify_mask (modify_mask),
        .woken_entry (woken_entry)
    );

    // full gates the push, so wr can follow mem_valid directly
    queue_nm #(
        .m_t      (mem_ex_pkg::mem_ex_mod_t),
        .n_t      (mem_ex_pkg::mem_ex_fix_t),
        .q_length (`MEM_EX_Q_LENGTH)
    ) u_queue (
        .clk           (clk),
        .arst_n        (arst_n),
        .wr            (mem_valid),
        .rd            (rd),
        .clr           (flush),
        .m_din         (woken_entry.mod),
        .n_din         (woken_entry.fix),
        .new_m_vector  (new_mod),
        .modify_vector (modify_mask),
        .full          (full),
        .empty         (empty),
        .old_m_vector  (old_mod),
        .dout_m        (head_m),
        .dout_n        (head_n)
    );

    // in-order pop and execute-side register
    ex_issue u_issue (
        .clk      (clk),
        .arst_n   (arst_n),
        .flush    (flush),
        .empty    (empty),
        .head_m   (head_m),
        .head_n   (head_n),
        .ex_ready (ex_ready),
        .rd       (rd),
        .ex_valid (ex_valid),
        .ex_entry (ex_entry)
    );

    assign mem_ready = ~full;

endmodule

`default_nettype wire

// ==== hw/ex_issue.sv ====
`default_nettype none
`include "mem_ex_settings.svh"

module ex_issue (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      flush,
    input  logic                      empty,
    input  mem_ex_pkg::mem_ex_mod_t   head_m,
    input  mem_ex_pkg::mem_ex_fix_t   head_n,
    input  logic                      ex_ready,
    output logic                      rd,
    output logic                      ex_valid,
    output mem_ex_pkg::mem_ex_entry_t ex_entry
);

    logic head_awake;
    logic out_free;

    // head may only go once all of its operands are present
    always_comb begin
        head_awake = 1'b1;
        for (int s = 0; s < `MEM_EX_NUM_OPS; s++) begin
            head_awake = head_awake && head_m[s].wake;
        end
    end

    // output register is free when empty or handed over this edge
    assign out_free = !ex_valid || ex_ready;

    assign rd = !empty && head_awake && !flush && out_free;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_valid <= 1'b0;
        end else if (flush) begin
            ex_valid <= 1'b0;
        end else if (rd) begin
            ex_valid <= 1'b1;
        end else if (ex_ready) begin
            ex_valid <= 1'b0;
        end
    end

    // payload only moves on a pop, so it holds under back-pressure
    always_ff @(posedge clk) begin
        if (rd) begin
            ex_entry.mod <= head_m;
            ex_entry.fix <= head_n;
        end
    end

endmodule

`default_nettype wire

// ==== hw/operand_wakeup.sv ====
`default_nettype none
`include "mem_ex_settings.svh"

module operand_wakeup (
    input  mem_ex_pkg::mem_ex_mod_t      old_mod [`MEM_EX_Q_LENGTH],
    input  mem_ex_pkg::mem_ex_entry_t    in_entry,
    input  mem_ex_pkg::result_bcast_t    bcast,
    output mem_ex_pkg::mem_ex_mod_t      new_mod [`MEM_EX_Q_LENGTH],
    output logic [`MEM_EX_Q_LENGTH-1:0] modify_mask,
    output mem_ex_pkg::mem_ex_entry_t    woken_entry
);

    // an asleep slot waiting on the broadcast producer
    function automatic logic slot_hit(
        input mem_ex_pkg::op_slot_t      slot,
        input mem_ex_pkg::result_bcast_t b
    );
        return b.valid && !slot.wake && (slot.tag == b.tag);
    endfunction

    // fill every matching slot with the broadcast value
    // awake slots pass through untouched
    function automatic mem_ex_pkg::mem_ex_mod_t wake_mod(
        input mem_ex_pkg::mem_ex_mod_t   mod,
        input mem_ex_pkg::result_bcast_t b
    );
        mem_ex_pkg::mem_ex_mod_t res;
        res = mod;
        for (int s = 0; s < `MEM_EX_NUM_OPS; s++) begin
            if (slot_hit(mod[s], b)) begin
                res[s].wake  = 1'b1;
                res[s].value = b.value;
            end
        end
        return res;
    endfunction

    // any hit in an entry
    function automatic logic mod_hit(
        input mem_ex_pkg::mem_ex_mod_t   mod,
        input mem_ex_pkg::result_bcast_t b
    );
        logic hit;
        hit = 1'b0;
        for (int s = 0; s < `MEM_EX_NUM_OPS; s++) begin
            hit = hit | slot_hit(mod[s], b);
        end
        return hit;
    endfunction

    // queued entries
    // the queue itself drops updates to slots that are not live
    always_comb begin
        for (int e = 0; e < `MEM_EX_Q_LENGTH; e++) begin
            new_mod[e]     = wake_mod(old_mod[e], bcast);
            modify_mask[e] = mod_hit(old_mod[e], bcast);
        end
    end

    // incoming entry is corrected before the write
    // otherwise a result in the accept cycle would be missed for good
    always_comb begin
        woken_entry.mod = wake_mod(in_entry.mod, bcast);
        woken_entry.fix = in_entry.fix;
    end

endmodule

`default_nettype wire

// ==== hw/queue_nm/queue_nm.sv ====
`default_nettype none

module queue_nm #(
    parameter type m_t      = logic [7:0],
    parameter type n_t      = logic [7:0],
    parameter int  q_length = 8
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                wr,
    input  logic                rd,
    input  logic                clr,
    input  m_t                  m_din,
    input  n_t                  n_din,
    input  m_t                  new_m_vector [q_length],
    input  logic [q_length-1:0] modify_vector,
    output logic                full,
    output logic                empty,
    output m_t                  old_m_vector [q_length],
    output m_t                  dout_m,
    output n_t                  dout_n
);

    localparam int PTR_W = (q_length > 1) ? $clog2(q_length) : 1;
    localparam int CNT_W = $clog2(q_length + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(q_length - 1);

    // entry storage, split into the two parts
    m_t m_mem [q_length];
    n_t n_mem [q_length];

    logic [PTR_W-1:0]    head;
    logic [PTR_W-1:0]    tail;
    logic [CNT_W-1:0]    count;
    logic [q_length-1:0] occupied;
    logic                do_wr;
    logic                do_rd;

    // circular increment, also for lengths that are not a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == LAST_PTR) ? '0 : p + 1'b1;
    endfunction

    assign full  = (count == CNT_W'(q_length));
    assign empty = (count == '0);

    // a push into a full queue is dropped
    assign do_wr = wr && !full;
    assign do_rd = rd && !empty;

    // slot i is live when its distance from head is below count
    always_comb begin
        for (int i = 0; i < q_length; i++) begin
            if (i >= int'(head)) begin
                occupied[i] = (i - int'(head)) < int'(count);
            end else begin
                occupied[i] = (i + q_length - int'(head)) < int'(count);
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (clr) begin
            // flush wins over a push or pop in the same cycle
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (do_wr) begin
                tail <= ptr_inc(tail);
            end
            if (do_rd) begin
                head <= ptr_inc(head);
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

    // in-place update of live entries, then the push at tail
    // tail is never live when a push is allowed so the two never collide
    always_ff @(posedge clk) begin
        for (int i = 0; i < q_length; i++) begin
            if (modify_vector[i] && occupied[i]) begin
                m_mem[i] <= new_m_vector[i];
            end
        end
        if (do_wr) begin
            m_mem[tail] <= m_din;
            n_mem[tail] <= n_din;
        end
    end

    // every modifiable part goes out for the wakeup compare
    assign old_m_vector = m_mem;

    // head entry, valid only while not empty
    assign dout_m = m_mem[head];
    assign dout_n = n_mem[head];

endmodule

`default_nettype wire

// ==== common/mem_ex_pkg.sv ====
`default_nettype none
`include "mem_ex_settings.svh"

package mem_ex_pkg;

    // one source operand as it sits in the queue
    // wake set means value holds the real operand
    // wake clear means value is stale and tag names the producer
    typedef struct packed {
        logic                     wake;
        logic [`MEM_EX_TAG_W-1:0] tag;
        logic [`MEM_EX_VAL_W-1:0] value;
    } op_slot_t;

    // modifiable part, rewritten in place by result broadcasts
    typedef op_slot_t [`MEM_EX_NUM_OPS-1:0] mem_ex_mod_t;

    // fixed part, written once at accept and never touched again
    typedef struct packed {
        logic [`MEM_EX_EIP_W-1:0]    eip;
        logic [`MEM_EX_ALUK_W-1:0]   aluk;
        logic [`MEM_EX_TAG_W-1:0]    dest_tag;
        logic [`MEM_EX_OPSIZE_W-1:0] opsize;
    } mem_ex_fix_t;

    // whole entry as pushed by mem and presented to ex
    typedef struct packed {
        mem_ex_mod_t mod;
        mem_ex_fix_t fix;
    } mem_ex_entry_t;

    // result broadcast from a later stage
    typedef struct packed {
        logic                     valid;
        logic [`MEM_EX_TAG_W-1:0] tag;
        logic [`MEM_EX_VAL_W-1:0] value;
    } result_bcast_t;

endpackage

`default_nettype wire

// ==== common/mem_ex_settings.svh ====
`ifndef MEM_EX_SETTINGS_SVH
`define MEM_EX_SETTINGS_SVH

// entries held between mem and ex, not counting the output register
`define MEM_EX_Q_LENGTH 8

// source operands carried by every entry
`define MEM_EX_NUM_OPS 2

// operand value and producer tag widths
`define MEM_EX_VAL_W 32
`define MEM_EX_TAG_W 4

// fixed part field widths
`define MEM_EX_EIP_W 32
`define MEM_EX_ALUK_W 5
`define MEM_EX_OPSIZE_W 2

`endif
